//--- source/gpuBackend_consts.svh
`ifndef GPUBACKEND_CONSTS_SVH
`define GPUBACKEND_CONSTS_SVH

// ----------------------------------------------------------
// Background block geometry
// ----------------------------------------------------------

// One block is 16 halfword pixels of a VRAM line
`define GPU_BLOCK_PIXELS 16
`define GPU_BLOCK_BITS 256
// Block address is screen Y plus X bits 9 to 4
`define GPU_BLOCK_ADR_W 15

// Screen coordinates
`define GPU_SCRX_W 10
`define GPU_SCRY_W 9

// ----------------------------------------------------------
// Color depth
// ----------------------------------------------------------

// Gouraud channels on input
`define GPU_COLOR_IN_W 8
// Stored channels in 15 bit VRAM format
`define GPU_COLOR_OUT_W 5

// Semi transparency modes, B is background and F foreground
`define GPU_TRANS_HALF 2'd0
`define GPU_TRANS_ADD 2'd1
`define GPU_TRANS_SUB 2'd2
`define GPU_TRANS_QUARTER 2'd3

`endif

//--- source/gpuPixelPkg.sv
`default_nettype none

`include "gpuBackend_consts.svh"

package gpuPixelPkg;

	// ----------------------------------------------------------
	// Incoming pixels
	// ----------------------------------------------------------

	// Gouraud color, one byte per channel
	typedef struct packed {
		logic [`GPU_COLOR_IN_W-1:0] b;
		logic [`GPU_COLOR_IN_W-1:0] g;
		logic [`GPU_COLOR_IN_W-1:0] r;
	} rgbIn_t;

	// Single pixel as delivered by the front end
	typedef struct packed {
		rgbIn_t color;
		logic valid;
		// Sticky mask bit written back with the pixel
		logic bgMask;
	} pixelIn_t;

	// Horizontally adjacent pair, left pixel sits at the even X
	typedef struct packed {
		pixelIn_t left;
		pixelIn_t right;
		logic [`GPU_SCRX_W-1:0] scrX;
		logic [`GPU_SCRY_W-1:0] scrY;
		// 00 none, 01 first block, 10 next block, 11 last
		logic [1:0] newBlock;
	} pairIn_t;

	// ----------------------------------------------------------
	// Background pixels
	// ----------------------------------------------------------

	// VRAM layout, mask on top then blue, green, red
	typedef struct packed {
		logic mask;
		logic [`GPU_COLOR_OUT_W-1:0] b;
		logic [`GPU_COLOR_OUT_W-1:0] g;
		logic [`GPU_COLOR_OUT_W-1:0] r;
	} bgPixelRgb_t;

	// Same halfword, raw for storage or split for blending
	typedef union packed {
		logic [15:0] raw;
		bgPixelRgb_t rgb;
	} bgPixel_u;

endpackage

`default_nettype wire

//--- source/gpuBlockPkg.sv
`default_nettype none

`include "gpuBackend_consts.svh"

package gpuBlockPkg;

	// ----------------------------------------------------------
	// Block addressing
	// ----------------------------------------------------------

	// Line number then 16 pixel column
	typedef struct packed {
		logic [`GPU_SCRY_W-1:0] scrY;
		logic [`GPU_BLOCK_ADR_W-`GPU_SCRY_W-1:0] blockX;
	} blockAdr_t;

	// Operation requested on the block memory
	typedef enum logic [1:0] {
		PAIR_NONE = 2'b00,
		PAIR_FIRST = 2'b01,
		PAIR_NEXT = 2'b10,
		PAIR_LAST = 2'b11
	} pairCode_t;

	// ----------------------------------------------------------
	// Write back outputs
	// ----------------------------------------------------------

	// Stencil cache update for one pair
	typedef struct packed {
		logic write;
		blockAdr_t adr;
		// Pair index inside the block
		logic [2:0] pairId;
		// Bit 1 right pixel, bit 0 left pixel
		logic [1:0] select;
		logic [1:0] value;
	} stencilWrite_t;

	// Whole cached block for the memory side
	typedef struct packed {
		logic [`GPU_BLOCK_BITS-1:0] block;
		logic [`GPU_BLOCK_PIXELS-1:0] mask;
	} blockExport_t;

endpackage

`default_nettype wire

//--- source/pixelPairStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpuBackend_consts.svh"

// Input register for one pixel pair
module pixelPairStage (
	input wire logic clk,
	input wire logic i_rst,
	input wire logic i_pause,
	input wire logic i_resetPixelOnNewBlock,
	input wire gpuPixelPkg::pairIn_t i_pair,
	output gpuPixelPkg::pairIn_t o_stagePair,
	output logic o_pixelInFlight
);

	// ----------------------------------------------------------
	// Control state
	// ----------------------------------------------------------

	logic leftValid;
	logic rightValid;
	logic [1:0] newBlock;

	// Pixel payload registers
	gpuPixelPkg::rgbIn_t leftColor;
	gpuPixelPkg::rgbIn_t rightColor;
	logic leftMask;
	logic rightMask;
	logic [`GPU_SCRX_W-1:0] scrX;
	logic [`GPU_SCRY_W-1:0] scrY;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			leftValid <= 1'b0;
			rightValid <= 1'b0;
			newBlock <= 2'b00;
		end else begin
			// Freeze everything while paused
			if (!i_pause) begin
				leftValid <= i_pair.left.valid;
				rightValid <= i_pair.right.valid;
				newBlock <= i_pair.newBlock;
			end
			// Block op acknowledged, clear wins over capture
			if (i_resetPixelOnNewBlock) begin
				newBlock <= 2'b00;
			end
		end
	end

	// ----------------------------------------------------------
	// Pixel payload
	// ----------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!i_pause) begin
			leftColor <= i_pair.left.color;
			rightColor <= i_pair.right.color;
			leftMask <= i_pair.left.bgMask;
			rightMask <= i_pair.right.bgMask;
			scrX <= i_pair.scrX;
			scrY <= i_pair.scrY;
		end
	end

	// Rebuild the pair for the blender and the cache
	always_comb begin
		o_stagePair.left.color = leftColor;
		o_stagePair.left.valid = leftValid;
		o_stagePair.left.bgMask = leftMask;
		o_stagePair.right.color = rightColor;
		o_stagePair.right.valid = rightValid;
		o_stagePair.right.bgMask = rightMask;
		o_stagePair.scrX = scrX;
		o_stagePair.scrY = scrY;
		o_stagePair.newBlock = newBlock;
	end

	// Either half still waiting for write back
	assign o_pixelInFlight = leftValid | rightValid;

endmodule

`default_nettype wire

//--- source/pairBlender.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpuBackend_consts.svh"

// Blends the stage pair against the cached background
module pairBlender (
	input wire gpuPixelPkg::pairIn_t i_stagePair,
	input wire logic [`GPU_BLOCK_BITS-1:0] i_block,
	input wire logic [1:0] i_transMode,
	input wire logic i_noBlend,
	output gpuPixelPkg::bgPixel_u o_left,
	output gpuPixelPkg::bgPixel_u o_right
);

	// ----------------------------------------------------------
	// Channel arithmetic
	// ----------------------------------------------------------

	// One extra bit catches overflow and borrow
	function automatic logic [`GPU_COLOR_OUT_W-1:0] blendChannel(
		input logic [`GPU_COLOR_OUT_W-1:0] bg,
		input logic [`GPU_COLOR_OUT_W-1:0] fg,
		input logic [1:0] mode
	);
		logic [`GPU_COLOR_OUT_W:0] sum;
		logic [`GPU_COLOR_OUT_W:0] diff;
		logic [`GPU_COLOR_OUT_W:0] quarterSum;
		logic [`GPU_COLOR_OUT_W-1:0] result;
		sum = {1'b0, bg} + {1'b0, fg};
		diff = {1'b0, bg} - {1'b0, fg};
		quarterSum = {1'b0, bg} + ({1'b0, fg} >> 2);
		case (mode)
			// Average, drop the low bit
			`GPU_TRANS_HALF: result = sum[`GPU_COLOR_OUT_W:1];
			// Saturate at full intensity
			`GPU_TRANS_ADD: result = sum[`GPU_COLOR_OUT_W]
				? {`GPU_COLOR_OUT_W{1'b1}} : sum[`GPU_COLOR_OUT_W-1:0];
			// Borrow means negative, floor at black
			`GPU_TRANS_SUB: result = diff[`GPU_COLOR_OUT_W]
				? '0 : diff[`GPU_COLOR_OUT_W-1:0];
			`GPU_TRANS_QUARTER: result = quarterSum[`GPU_COLOR_OUT_W]
				? {`GPU_COLOR_OUT_W{1'b1}} : quarterSum[`GPU_COLOR_OUT_W-1:0];
			default: result = bg;
		endcase
		return result;
	endfunction

	// Whole pixel, foreground truncated to the stored depth
	function automatic gpuPixelPkg::bgPixel_u blendPixel(
		input gpuPixelPkg::bgPixel_u bg,
		input gpuPixelPkg::pixelIn_t fg,
		input logic [1:0] mode,
		input logic noBlend
	);
		gpuPixelPkg::bgPixel_u result;
		logic [`GPU_COLOR_OUT_W-1:0] fgR;
		logic [`GPU_COLOR_OUT_W-1:0] fgG;
		logic [`GPU_COLOR_OUT_W-1:0] fgB;
		// Keep the top bits of each channel
		fgR = fg.color.r[`GPU_COLOR_IN_W-1 -: `GPU_COLOR_OUT_W];
		fgG = fg.color.g[`GPU_COLOR_IN_W-1 -: `GPU_COLOR_OUT_W];
		fgB = fg.color.b[`GPU_COLOR_IN_W-1 -: `GPU_COLOR_OUT_W];
		if (noBlend) begin
			result.rgb.r = fgR;
			result.rgb.g = fgG;
			result.rgb.b = fgB;
		end else begin
			result.rgb.r = blendChannel(bg.rgb.r, fgR, mode);
			result.rgb.g = blendChannel(bg.rgb.g, fgG, mode);
			result.rgb.b = blendChannel(bg.rgb.b, fgB, mode);
		end
		// Mask comes from the primitive, not the background
		result.rgb.mask = fg.bgMask;
		return result;
	endfunction

	// ----------------------------------------------------------
	// Background pair select
	// ----------------------------------------------------------

	localparam int HALF_W = $bits(gpuPixelPkg::bgPixel_u);

	logic [2:0] pairId;
	logic [3:0] leftIdx;
	logic [3:0] rightIdx;
	gpuPixelPkg::bgPixel_u bgLeft;
	gpuPixelPkg::bgPixel_u bgRight;

	// Pair index is X bits 3 to 1, left halfword is even
	assign pairId = i_stagePair.scrX[3:1];
	assign leftIdx = {pairId, 1'b0};
	assign rightIdx = {pairId, 1'b1};

	assign bgLeft.raw = i_block[leftIdx*HALF_W +: HALF_W];
	assign bgRight.raw = i_block[rightIdx*HALF_W +: HALF_W];

	assign o_left = blendPixel(bgLeft, i_stagePair.left, i_transMode, i_noBlend);
	assign o_right = blendPixel(bgRight, i_stagePair.right, i_transMode, i_noBlend);

endmodule

`default_nettype wire

//--- source/bgBlockCache.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpuBackend_consts.svh"

// Background block cache and write back control
module bgBlockCache (
	input wire logic clk,
	input wire logic i_rst,
	input wire logic i_pause,
	input wire gpuPixelPkg::pairIn_t i_stagePair,
	input wire gpuPixelPkg::bgPixel_u i_left,
	input wire gpuPixelPkg::bgPixel_u i_right,
	input wire logic i_noBlend,
	input wire logic i_flushLastBlock,
	input wire logic i_resetPixelMask,
	input wire logic i_importBlock,
	input wire logic [`GPU_BLOCK_BITS-1:0] i_importedBlock,
	output logic [`GPU_BLOCK_BITS-1:0] o_block,
	output gpuBlockPkg::stencilWrite_t o_stencil,
	output gpuBlockPkg::blockAdr_t o_loadAdr,
	output gpuBlockPkg::blockAdr_t o_saveAdr,
	output gpuBlockPkg::pairCode_t o_saveBlock,
	output logic o_writePixelOnNewBlock,
	output gpuBlockPkg::blockExport_t o_export
);

	localparam int HALF_W = $bits(gpuPixelPkg::bgPixel_u);

	logic [`GPU_BLOCK_BITS-1:0] cacheBlock;
	logic [`GPU_BLOCK_PIXELS-1:0] cacheMsk;
	gpuBlockPkg::blockAdr_t lastWriteAdr;
	gpuBlockPkg::blockAdr_t writeAdr;
	gpuBlockPkg::pairCode_t stageCode;
	gpuBlockPkg::pairCode_t pairCode;
	logic writeSig;
	logic [2:0] pairId;
	logic [3:0] leftIdx;
	logic [3:0] rightIdx;

	// ----------------------------------------------------------
	// Write decode
	// ----------------------------------------------------------

	assign writeAdr.scrY = i_stagePair.scrY;
	assign writeAdr.blockX = i_stagePair.scrX[`GPU_SCRX_W-1:4];
	assign pairId = i_stagePair.scrX[3:1];
	assign leftIdx = {pairId, 1'b0};
	assign rightIdx = {pairId, 1'b1};

	// Any valid half of an unpaused pair gets written
	assign writeSig = !i_pause & (i_stagePair.left.valid | i_stagePair.right.valid);

	// Stencil command mirrors the stage pair
	assign o_stencil.write = writeSig;
	assign o_stencil.adr = writeAdr;
	assign o_stencil.pairId = pairId;
	assign o_stencil.select = {i_stagePair.right.valid, i_stagePair.left.valid};
	assign o_stencil.value = {
		i_stagePair.right.bgMask & i_stagePair.right.valid,
		i_stagePair.left.bgMask & i_stagePair.left.valid
	};

	// ----------------------------------------------------------
	// Block op code
	// ----------------------------------------------------------

	assign stageCode = gpuBlockPkg::pairCode_t'(i_stagePair.newBlock);

	// No load needed on a first block without blending
	always_comb begin
		pairCode = stageCode;
		if (stageCode == gpuBlockPkg::PAIR_FIRST && i_noBlend) begin
			pairCode = gpuBlockPkg::PAIR_NONE;
		end
		// Flush turns any code into last block
		pairCode = gpuBlockPkg::pairCode_t'(pairCode | {2{i_flushLastBlock}});
	end

	assign o_saveBlock = pairCode;
	assign o_writePixelOnNewBlock = (pairCode != gpuBlockPkg::PAIR_NONE);

	// ----------------------------------------------------------
	// Cache storage
	// ----------------------------------------------------------

	// Import only lands in a cycle without pixel write
	always_ff @(posedge clk) begin
		if (writeSig) begin
			if (i_stagePair.left.valid) begin
				cacheBlock[leftIdx*HALF_W +: HALF_W] <= i_left.raw;
			end
			if (i_stagePair.right.valid) begin
				cacheBlock[rightIdx*HALF_W +: HALF_W] <= i_right.raw;
			end
			lastWriteAdr <= writeAdr;
		end else if (i_importBlock) begin
			cacheBlock <= i_importedBlock;
		end
	end

	// Touched pixel flags
	always_ff @(posedge clk) begin
		if (i_rst) begin
			cacheMsk <= '0;
		end else if (writeSig) begin
			if (i_stagePair.left.valid) begin
				cacheMsk[leftIdx] <= 1'b1;
			end
			if (i_stagePair.right.valid) begin
				cacheMsk[rightIdx] <= 1'b1;
			end
		end else if (i_resetPixelMask) begin
			cacheMsk <= '0;
		end
	end

	assign o_block = cacheBlock;
	assign o_loadAdr = writeAdr;
	assign o_saveAdr = lastWriteAdr;
	assign o_export.block = cacheBlock;
	assign o_export.mask = cacheMsk;

endmodule

`default_nettype wire

//--- source/gpuBackend.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpuBackend_consts.svh"

// Write back half of the GPU back end
module gpuBackend (
	input wire logic clk,
	input wire logic i_rst,

	// Pipeline control
	input wire logic i_pause,
	input wire logic i_resetPixelOnNewBlock,
	input wire logic i_resetPixelMask,
	output logic o_pixelInFlight,
	output logic o_writePixelOnNewBlock,

	// Primitive setup
	input wire logic [1:0] i_transMode,
	input wire logic i_noBlend,
	input wire logic i_flushLastBlock,

	// Pixel pair from the front end
	input wire gpuPixelPkg::pairIn_t i_pair,

	// Stencil and block memory side
	output gpuBlockPkg::stencilWrite_t o_stencil,
	output gpuBlockPkg::blockAdr_t o_loadAdr,
	output gpuBlockPkg::blockAdr_t o_saveAdr,
	output gpuBlockPkg::pairCode_t o_saveBlock,
	output gpuBlockPkg::blockExport_t o_export,
	input wire logic i_importBlock,
	input wire logic [`GPU_BLOCK_BITS-1:0] i_importedBlock
);

	// ----------------------------------------------------------
	// Internal wiring
	// ----------------------------------------------------------

	gpuPixelPkg::pairIn_t stagePair;
	gpuPixelPkg::bgPixel_u blendLeft;
	gpuPixelPkg::bgPixel_u blendRight;
	logic [`GPU_BLOCK_BITS-1:0] curBlock;

	// Input stage
	pixelPairStage u_stage (
		.clk(clk),
		.i_rst(i_rst),
		.i_pause(i_pause),
		.i_resetPixelOnNewBlock(i_resetPixelOnNewBlock),
		.i_pair(i_pair),
		.o_stagePair(stagePair),
		.o_pixelInFlight(o_pixelInFlight)
	);

	// Blend against the cached background
	pairBlender u_blender (
		.i_stagePair(stagePair),
		.i_block(curBlock),
		.i_transMode(i_transMode),
		.i_noBlend(i_noBlend),
		.o_left(blendLeft),
		.o_right(blendRight)
	);

	// Block cache and memory side outputs
	bgBlockCache u_cache (
		.clk(clk),
		.i_rst(i_rst),
		.i_pause(i_pause),
		.i_stagePair(stagePair),
		.i_left(blendLeft),
		.i_right(blendRight),
		.i_noBlend(i_noBlend),
		.i_flushLastBlock(i_flushLastBlock),
		.i_resetPixelMask(i_resetPixelMask),
		.i_importBlock(i_importBlock),
		.i_importedBlock(i_importedBlock),
		.o_block(curBlock),
		.o_stencil(o_stencil),
		.o_loadAdr(o_loadAdr),
		.o_saveAdr(o_saveAdr),
		.o_saveBlock(o_saveBlock),
		.o_writePixelOnNewBlock(o_writePixelOnNewBlock),
		.o_export(o_export)
	);

endmodule

`default_nettype wire

//--- sim/gpuBackend_properties.sv
`timescale 1ns/1ps
`default_nettype none

// Protocol checks bound into the back end top level
module gpuBackendProperties (
	input wire logic clk,
	input wire logic i_rst,
	input wire logic i_pause,
	input wire logic i_importBlock,
	input wire gpuBlockPkg::stencilWrite_t o_stencil,
	input wire logic o_pixelInFlight,
	input wire gpuBlockPkg::blockExport_t o_export
);

	// ----------------------------------------------------------
	// Reset state
	// ----------------------------------------------------------

	// Nothing in flight and an empty mask right after reset
	resetIdle: assert property (@(posedge clk)
		i_rst |=> (!o_pixelInFlight && !o_stencil.write && o_export.mask == '0))
		else $error("Back end not idle after reset");

	// ----------------------------------------------------------
	// Pause
	// ----------------------------------------------------------

	// Stage keeps its pair over a paused edge
	pauseHoldsStage: assert property (@(posedge clk) disable iff (i_rst)
		i_pause |=> ($stable(o_stencil.adr) && $stable(o_stencil.pairId)
			&& $stable(o_stencil.select) && $stable(o_stencil.value)
			&& $stable(o_pixelInFlight)))
		else $error("Stage pair changed while paused");

	// No pixel lands in the cache while paused
	pauseHoldsBlock: assert property (@(posedge clk) disable iff (i_rst)
		(i_pause && !i_importBlock) |=> $stable(o_export.block))
		else $error("Cached block changed while paused");

	// ----------------------------------------------------------
	// Stencil against cache
	// ----------------------------------------------------------

	// Every selected pixel of a written pair is marked afterwards
	stencilMarksMask: assert property (@(posedge clk) disable iff (i_rst)
		o_stencil.write |=>
			((2'(o_export.mask >> {$past(o_stencil.pairId), 1'b0})
				& $past(o_stencil.select)) == $past(o_stencil.select)))
		else $error("Written pixels missing from the block mask");

endmodule

bind gpuBackend gpuBackendProperties u_props (
	.clk(clk),
	.i_rst(i_rst),
	.i_pause(i_pause),
	.i_importBlock(i_importBlock),
	.o_stencil(o_stencil),
	.o_pixelInFlight(o_pixelInFlight),
	.o_export(o_export)
);

`default_nettype wire

//--- sim/gpuBackendTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpuBackend_consts.svh"

module gpuBackendTb;

	logic clk;
	logic rst;
	logic pause;
	logic clrCode;
	logic clrMask;
	logic [1:0] transMode;
	logic noBlend;
	logic flush;
	logic importBlock;
	logic [`GPU_BLOCK_BITS-1:0] importedBlock;
	gpuPixelPkg::pairIn_t pair;
	gpuBlockPkg::stencilWrite_t stencil;
	gpuBlockPkg::blockAdr_t loadAdr;
	gpuBlockPkg::blockAdr_t saveAdr;
	gpuBlockPkg::pairCode_t saveBlock;
	logic writeOnNew;
	logic inFlight;
	gpuBlockPkg::blockExport_t exportBus;

	// Reference copy of the cache
	logic [`GPU_BLOCK_BITS-1:0] modelBlock;
	logic [`GPU_BLOCK_PIXELS-1:0] modelMask;
	logic [14:0] modelSaveAdr;
	int errors;
	int seed;

	// Fields of one test line
	logic [31:0] fOp, fPause, fTrans, fNoBlend, fFlush, fClrCode, fX, fY;
	logic [31:0] fLv, fLm, fLc, fRv, fRm, fRc, fCode, fExpSave, fExpWnb;

	gpuBackend i_dut (
		.clk(clk),
		.i_rst(rst),
		.i_pause(pause),
		.i_resetPixelOnNewBlock(clrCode),
		.i_resetPixelMask(clrMask),
		.o_pixelInFlight(inFlight),
		.o_writePixelOnNewBlock(writeOnNew),
		.i_transMode(transMode),
		.i_noBlend(noBlend),
		.i_flushLastBlock(flush),
		.i_pair(pair),
		.o_stencil(stencil),
		.o_loadAdr(loadAdr),
		.o_saveAdr(saveAdr),
		.o_saveBlock(saveBlock),
		.o_export(exportBus),
		.i_importBlock(importBlock),
		.i_importedBlock(importedBlock)
	);

	always #50 clk = ~clk;

	// Hard stop if the clock loop never ends
	initial begin
		#2000000;
		$display("Timeout: simulation ran past its time limit");
		$display("tests failed");
		$finish;
	end

	// ----------------------------------------------------------
	// Helpers
	// ----------------------------------------------------------

	task automatic waitFalling;
		int edges;
		edges = 0;
		@(clk);
		while (clk !== 1'b0 && edges < 4) begin
			@(clk);
			edges++;
		end
		if (clk !== 1'b0) begin
			$display("Timeout: no falling clock edge seen");
			$display("tests failed");
			$finish;
		end
	endtask

	task automatic compareValue(input string name, input logic [255:0] got,
		input logic [255:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	// One channel by the transparency rules, clamped to 0..31
	function automatic int mixChannel(input int b, input int f, input logic [1:0] mode);
		int r;
		case (mode)
			2'd0: r = (b + f) / 2;
			2'd1: r = b + f;
			2'd2: r = b - f;
			default: r = b + f / 4;
		endcase
		if (r > 31) r = 31;
		if (r < 0) r = 0;
		return r;
	endfunction

	function automatic logic [15:0] expectedPixel(input logic [15:0] bg,
		input logic [23:0] color, input logic mask, input logic [1:0] mode, input logic nb);
		int fR, fG, fB, oR, oG, oB;
		fR = int'(color[7:3]);
		fG = int'(color[15:11]);
		fB = int'(color[23:19]);
		if (nb) begin
			oR = fR;
			oG = fG;
			oB = fB;
		end else begin
			oR = mixChannel(int'(bg[4:0]), fR, mode);
			oG = mixChannel(int'(bg[9:5]), fG, mode);
			oB = mixChannel(int'(bg[14:10]), fB, mode);
		end
		return {mask, oB[4:0], oG[4:0], oR[4:0]};
	endfunction

	task automatic drivePair;
		pause = fPause[0];
		transMode = fTrans[1:0];
		noBlend = fNoBlend[0];
		flush = fFlush[0];
		clrCode = fClrCode[0];
		pair.left.color = fLc[23:0];
		pair.left.valid = fLv[0];
		pair.left.bgMask = fLm[0];
		pair.right.color = fRc[23:0];
		pair.right.valid = fRv[0];
		pair.right.bgMask = fRm[0];
		pair.scrX = fX[9:0];
		pair.scrY = fY[8:0];
		pair.newBlock = fCode[1:0];
	endtask

	task automatic driveIdle;
		pair.left.valid = 1'b0;
		pair.right.valid = 1'b0;
		pair.newBlock = 2'b00;
	endtask

	// Combinational outputs for the pair now in the stage
	task automatic checkStage(input logic expWrite);
		logic [14:0] adr;
		adr = {fY[8:0], fX[9:4]};
		compareValue("o_stencil.write", 256'(stencil.write), 256'(expWrite));
		compareValue("o_stencil.adr", 256'(stencil.adr), 256'(adr));
		compareValue("o_stencil.pairId", 256'(stencil.pairId), 256'(fX[3:1]));
		compareValue("o_stencil.select", 256'(stencil.select), 256'({fRv[0], fLv[0]}));
		compareValue("o_stencil.value", 256'(stencil.value),
			256'({fRm[0] & fRv[0], fLm[0] & fLv[0]}));
		compareValue("o_loadAdr", 256'(loadAdr), 256'(adr));
		compareValue("o_saveBlock", 256'(saveBlock), 256'(fExpSave[1:0]));
		compareValue("o_writePixelOnNewBlock", 256'(writeOnNew), 256'(fExpWnb[0]));
		compareValue("o_pixelInFlight", 256'(inFlight), 256'(fLv[0] | fRv[0]));
	endtask

	task automatic updateModel;
		int base;
		base = int'(fX[3:1]) * 32;
		if (fLv[0]) begin
			modelBlock[base +: 16] = expectedPixel(modelBlock[base +: 16], fLc[23:0],
				fLm[0], fTrans[1:0], fNoBlend[0]);
			modelMask[base / 16] = 1'b1;
		end
		if (fRv[0]) begin
			modelBlock[base + 16 +: 16] = expectedPixel(modelBlock[base + 16 +: 16],
				fRc[23:0], fRm[0], fTrans[1:0], fNoBlend[0]);
			modelMask[base / 16 + 1] = 1'b1;
		end
		if (fLv[0] | fRv[0]) modelSaveAdr = {fY[8:0], fX[9:4]};
	endtask

	task automatic checkCache;
		compareValue("o_export.block", exportBus.block, modelBlock);
		compareValue("o_export.mask", 256'(exportBus.mask), 256'(modelMask));
		compareValue("o_saveAdr", 256'(saveAdr), 256'(modelSaveAdr));
	endtask

	// ----------------------------------------------------------
	// Main sequence
	// ----------------------------------------------------------

	initial begin
		int fd;
		int n;
		string line;
		logic [255:0] held;
		clk = 1'b0;
		rst = 1'b1;
		pause = 1'b0;
		clrCode = 1'b0;
		clrMask = 1'b0;
		transMode = 2'd0;
		noBlend = 1'b0;
		flush = 1'b0;
		importBlock = 1'b0;
		importedBlock = '0;
		pair = '0;
		errors = 0;
		seed = 32'ha881_7a2b;
		modelMask = '0;
		waitFalling();
		waitFalling();
		rst = 1'b0;
		waitFalling();
		compareValue("o_stencil.write", 256'(stencil.write), 256'(0));
		compareValue("o_saveBlock", 256'(saveBlock), 256'(0));
		compareValue("o_writePixelOnNewBlock", 256'(writeOnNew), 256'(0));
		compareValue("o_pixelInFlight", 256'(inFlight), 256'(0));
		compareValue("o_export.mask", 256'(exportBus.mask), 256'(0));

		fd = $fopen("sim/gpuBackend_tests.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open the test vector file");
		end
		while (fd != 0 && !$feof(fd)) begin
			if ($fgets(line, fd) == 0) break;
			if (line.len() < 2 || line.getc(0) == 8'h23) continue;
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				fOp, fPause, fTrans, fNoBlend, fFlush, fClrCode, fX, fY,
				fLv, fLm, fLc, fRv, fRm, fRc, fCode, fExpSave, fExpWnb);
			if (n != 17) begin
				errors++;
				$display("Malformed test line: %s", line);
				continue;
			end
			case (fOp)
				// Random background block
				0: begin
					for (int w = 0; w < 8; w++) importedBlock[w*32 +: 32] = $random(seed);
					importBlock = 1'b1;
					driveIdle();
					waitFalling();
					importBlock = 1'b0;
					modelBlock = importedBlock;
					compareValue("o_export.block", exportBus.block, modelBlock);
				end
				1: begin
					drivePair();
					waitFalling();
					checkStage(fLv[0] | fRv[0]);
					updateModel();
					driveIdle();
					waitFalling();
					checkCache();
				end
				// Pair held by pause for one cycle
				2: begin
					drivePair();
					waitFalling();
					checkStage(fLv[0] | fRv[0]);
					updateModel();
					pause = 1'b1;
					driveIdle();
					held = exportBus.block;
					waitFalling();
					compareValue("o_stencil.write", 256'(stencil.write), 256'(0));
					compareValue("o_export.block", exportBus.block, held);
					compareValue("o_pixelInFlight", 256'(inFlight), 256'(fLv[0] | fRv[0]));
					pause = 1'b0;
					waitFalling();
					checkCache();
				end
				// Control levels only, no pixels
				3: begin
					drivePair();
					waitFalling();
					compareValue("o_saveBlock", 256'(saveBlock), 256'(fExpSave[1:0]));
					compareValue("o_writePixelOnNewBlock", 256'(writeOnNew), 256'(fExpWnb[0]));
					flush = 1'b0;
					clrCode = 1'b0;
					pause = 1'b0;
					driveIdle();
				end
				4: begin
					clrMask = 1'b1;
					driveIdle();
					waitFalling();
					clrMask = 1'b0;
					modelMask = '0;
					compareValue("o_export.mask", 256'(exportBus.mask), 256'(0));
				end
				default: begin
					errors++;
					$display("Unknown operation code %0d in test file", fOp);
				end
			endcase
		end
		if (fd != 0) $fclose(fd);

		$display("Checks done with %0d errors", errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- gpuBackend.f
+incdir+source
source/gpuPixelPkg.sv
source/gpuBlockPkg.sv
source/pixelPairStage.sv
source/pairBlender.sv
source/bgBlockCache.sv
source/gpuBackend.sv
sim/gpuBackend_properties.sv
sim/gpuBackendTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# Build and run the gpuBackend testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f gpuBackend.f --top-module gpuBackendTb
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/VgpuBackendTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- sim/gpuBackend_tests.txt
# op pause trans noBlend flush clrCode scrX scrY lValid lMask lColor rValid rMask rColor code expSave expWnb
# op 0 import, 1 pair, 2 pause, 3 control only, 4 mask clear; colors are bbggrr hex
0 0 0 0 0 0 000 000 0 0 000000 0 0 000000 0 0 0
1 0 0 0 0 0 012 034 1 0 f08040 1 1 ffffff 0 0 0
1 0 1 0 0 0 014 034 1 1 808080 1 0 ff00ff 0 0 0
1 0 2 0 0 0 016 034 1 0 ff0810 1 0 000000 2 2 1
1 0 3 0 0 0 018 034 1 1 ffffff 0 0 123456 0 0 0
1 0 3 0 0 0 01e 034 0 0 000000 1 1 c0c0c0 0 0 0
1 0 1 0 0 0 010 034 1 1 f8f8f8 1 1 f8f8f8 0 0 0
0 0 0 0 0 0 000 000 0 0 000000 0 0 000000 0 0 0
1 0 1 1 0 0 020 100 1 1 abcdef 1 0 123456 1 0 0
1 0 0 1 0 0 02a 100 1 0 fedcba 1 1 0f0f0f 3 3 1
1 0 2 0 0 0 02c 101 1 1 204080 1 0 ffffff 1 1 1
1 0 0 0 0 0 02e 101 0 0 000000 1 1 7f7f7f 0 0 0
2 0 1 0 0 0 3f0 1ff 1 1 c08010 1 0 204080 2 2 1
2 0 2 0 0 0 3f6 1ff 0 0 000000 1 1 101010 0 0 0
3 0 0 0 0 0 000 000 0 0 000000 0 0 000000 2 2 1
3 1 0 0 0 1 000 000 0 0 000000 0 0 000000 0 0 0
3 0 0 0 1 0 000 000 0 0 000000 0 0 000000 0 3 1
4 0 0 0 0 0 000 000 0 0 000000 0 0 000000 0 0 0
1 0 3 0 0 0 03c 055 1 0 088888 1 1 ff0000 0 0 0
1 0 0 1 0 0 03e 055 1 1 00ff00 0 0 000000 0 0 0
0 0 0 0 0 0 000 000 0 0 000000 0 0 000000 0 0 0
1 0 2 0 0 0 004 077 1 1 ffffff 1 1 ffffff 2 2 1
1 0 0 0 1 0 006 077 1 0 404040 0 0 000000 0 3 1
